//--- verilog/ex_config.svh
`ifndef EX_CONFIG_SVH
`define EX_CONFIG_SVH

// data path width
`define EX_WORD_WIDTH 32

// register index width
`define EX_REG_BITS 3

// bit positions in the flags word
`define EX_FLAG_CF 0
`define EX_FLAG_ZF 6
`define EX_FLAG_SF 7
`define EX_FLAG_OF 11

`endif

//--- verilog/ex_pkg.sv
`include "ex_config.svh"

package ex_pkg;

  typedef logic [`EX_WORD_WIDTH-1:0] word_t;
  typedef logic [`EX_WORD_WIDTH-1:0] addr_t;
  typedef logic [`EX_REG_BITS-1:0] reg_idx_t;
  // 0 is 8-bit, 1 is 16-bit, 2 is 32-bit
  typedef logic [1:0] size_t;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_NOT_A,
    ALU_PASS_B,
    ALU_INC
  } alu_op_t;

  typedef struct packed {
    addr_t    neip;
    reg_idx_t dr1;
    reg_idx_t dr2;
    word_t    a;
    word_t    b;
    word_t    c;
    size_t    datasize;
    alu_op_t  aluk;
    logic     shift_dir;
    logic     use_shifter;
    logic     pass_a;
    logic     is_xchg;
    logic     is_cmpxchg;
    logic     is_cmps_first;
    logic     is_cmps_second;
    logic     ld_gpr1;
    logic     ld_gpr2;
    logic     dcache_write;
  } ex_uop_t;

  typedef struct packed {
    logic     valid;
    addr_t    neip;
    reg_idx_t dr1;
    reg_idx_t dr2;
    size_t    datasize;
    word_t    result_a;
    word_t    result_b;
    word_t    flags;
    logic     ld_gpr1;
    logic     ld_gpr2;
    logic     dcache_write;
  } wb_bundle_t;

  typedef struct packed {
    logic ld_gpr1;
    logic ld_gpr2;
    logic dcache_write;
  } dep_t;

  // ones over the active width of a data size
  function automatic word_t size_mask(input size_t size);
    case (size)
      2'd0:    return word_t'(32'h0000_00ff);
      2'd1:    return word_t'(32'h0000_ffff);
      default: return '1;
    endcase
  endfunction

  // sign bit of a data size
  function automatic word_t size_msb(input size_t size);
    case (size)
      2'd0:    return word_t'(32'h0000_0080);
      2'd1:    return word_t'(32'h0000_8000);
      default: return {1'b1, {(`EX_WORD_WIDTH-1){1'b0}}};
    endcase
  endfunction

endpackage

//--- verilog/ex_input_latch.sv
`timescale 1ns/100ps

module ex_input_latch (
  input  logic             clk,
  input  logic             reset,
  input  logic             ex_v,
  input  ex_pkg::ex_uop_t  ex_in,
  input  logic             stall,
  output ex_pkg::ex_uop_t  uop,
  output logic             uop_valid
);
  import ex_pkg::*;

  // valid bit
  always_ff @(posedge clk) begin
    if (reset) begin
      uop_valid <= 1'b0;
    end else if (!stall) begin
      uop_valid <= ex_v;
    end
  end

  // micro-op payload
  always_ff @(posedge clk) begin
    if (!stall) begin
      uop <= ex_in;
    end
  end

endmodule

//--- verilog/operand_select_ex.sv
`timescale 1ns/100ps

module operand_select_ex (
  input  logic             clk,
  input  logic             reset,
  input  logic             uop_valid,
  input  logic             stall,
  input  ex_pkg::ex_uop_t  uop,
  output ex_pkg::word_t    b_sel
);
  import ex_pkg::*;

  word_t cmps_a;
  logic  cmps_load;

  // first CMPS uop leaves its A for the second one
  assign cmps_load = uop_valid && uop.is_cmps_first && !stall;

  always_ff @(posedge clk) begin
    if (reset) begin
      cmps_a <= '0;
    end else if (cmps_load) begin
      cmps_a <= uop.a;
    end
  end

  assign b_sel = uop.is_cmps_second ? cmps_a : uop.b;

endmodule

//--- verilog/alu32.sv
`include "ex_config.svh"
`timescale 1ns/100ps

module alu32 (
  input  ex_pkg::word_t    a,
  input  ex_pkg::word_t    b,
  input  ex_pkg::alu_op_t  aluk,
  input  ex_pkg::size_t    datasize,
  output ex_pkg::word_t    result,
  output ex_pkg::word_t    flags
);
  import ex_pkg::*;

  word_t                   mask;
  word_t                   msb;
  word_t                   am;
  word_t                   bm;
  word_t                   res;
  logic [`EX_WORD_WIDTH:0] wide;
  logic [`EX_WORD_WIDTH:0] carry_bit;
  logic                    sa;
  logic                    sb;
  logic                    sr;
  logic                    cf;
  logic                    of;

  always_comb begin
    mask      = size_mask(datasize);
    msb       = size_msb(datasize);
    am        = a & mask;
    bm        = b & mask;
    carry_bit = {msb, 1'b0};
    case (aluk)
      ALU_ADD:    wide = {1'b0, am} + {1'b0, bm};
      ALU_SUB:    wide = {1'b0, am} - {1'b0, bm};
      ALU_INC:    wide = {1'b0, am} + 1'b1;
      ALU_AND:    wide = {1'b0, am & bm};
      ALU_OR:     wide = {1'b0, am | bm};
      ALU_XOR:    wide = {1'b0, am ^ bm};
      ALU_NOT_A:  wide = {1'b0, ~am};
      default:    wide = {1'b0, bm};
    endcase
    res = wide[`EX_WORD_WIDTH-1:0] & mask;
    sa  = |(am & msb);
    sb  = |(bm & msb);
    sr  = |(res & msb);
    // carry or borrow sits one above the size msb
    cf  = 1'b0;
    of  = 1'b0;
    case (aluk)
      ALU_ADD: begin
        cf = |(wide & carry_bit);
        of = (sa == sb) && (sr != sa);
      end
      ALU_INC: begin
        cf = |(wide & carry_bit);
        of = !sa && sr;
      end
      ALU_SUB: begin
        cf = |(wide & carry_bit);
        of = (sa != sb) && (sr != sa);
      end
      default: begin
        cf = 1'b0;
        of = 1'b0;
      end
    endcase
    flags              = '0;
    flags[`EX_FLAG_CF] = cf;
    flags[`EX_FLAG_ZF] = (res == '0);
    flags[`EX_FLAG_SF] = sr;
    flags[`EX_FLAG_OF] = of;
    result             = res;
  end

endmodule

//--- verilog/shifter32.sv
`include "ex_config.svh"
`timescale 1ns/100ps

module shifter32 (
  input  logic           shift_dir,
  input  ex_pkg::word_t  a,
  input  ex_pkg::word_t  b,
  input  ex_pkg::size_t  datasize,
  output ex_pkg::word_t  result,
  output ex_pkg::word_t  flags
);
  import ex_pkg::*;

  word_t                   mask;
  word_t                   am;
  word_t                   res;
  logic [4:0]              cnt;
  logic [`EX_WORD_WIDTH:0] left_wide;
  logic [`EX_WORD_WIDTH:0] right_wide;
  logic                    in_range;
  logic                    cf;

  always_comb begin
    mask       = size_mask(datasize);
    am         = a & mask;
    cnt        = b[4:0];
    left_wide  = {1'b0, am} << cnt;
    right_wide = {am, 1'b0} >> cnt;
    // count is nonzero and below the operand width
    in_range   = (cnt != 5'd0) && (|(mask >> cnt));
    if (shift_dir) begin
      res = right_wide[`EX_WORD_WIDTH:1];
      cf  = in_range && right_wide[0];
    end else begin
      res = left_wide[`EX_WORD_WIDTH-1:0] & mask;
      // bit pushed just past the size msb
      cf  = in_range && (|(left_wide & {size_msb(datasize), 1'b0}));
    end
    flags              = '0;
    flags[`EX_FLAG_CF] = cf;
    flags[`EX_FLAG_ZF] = (res == '0);
    flags[`EX_FLAG_SF] = |(res & size_msb(datasize));
    result             = res;
  end

endmodule

//--- verilog/result_select_ex.sv
`include "ex_config.svh"
`timescale 1ns/100ps

module result_select_ex (
  input  ex_pkg::ex_uop_t  uop,
  input  logic             uop_valid,
  input  ex_pkg::word_t    alu_result,
  input  ex_pkg::word_t    alu_flags,
  input  ex_pkg::word_t    shift_result,
  input  ex_pkg::word_t    shift_flags,
  output ex_pkg::word_t    result_a,
  output ex_pkg::word_t    result_b,
  output ex_pkg::word_t    flags,
  output logic             ld_gpr1,
  output logic             ld_gpr2,
  output logic             dcache_write,
  output ex_pkg::dep_t     dep
);
  import ex_pkg::*;

  logic zf;
  logic xchg_fail;

  assign flags     = uop.use_shifter ? shift_flags : alu_flags;
  assign zf        = flags[`EX_FLAG_ZF];
  // compare miss on cmpxchg loads the accumulator instead
  assign xchg_fail = uop.is_cmpxchg && !zf;

  always_comb begin
    if (uop.pass_a) begin
      result_a = uop.a;
      result_b = uop.c;
    end else if (uop.is_xchg) begin
      result_a = uop.b;
      result_b = uop.a;
    end else if (uop.is_cmpxchg) begin
      result_a = zf ? uop.c : alu_result;
      result_b = zf ? uop.c : uop.a;
    end else begin
      result_a = uop.use_shifter ? shift_result : alu_result;
      result_b = uop.c;
    end
  end

  always_comb begin
    if (uop.is_cmpxchg) begin
      ld_gpr1      = uop.ld_gpr1 && !xchg_fail;
      ld_gpr2      = xchg_fail;
      dcache_write = uop.dcache_write && !xchg_fail;
    end else begin
      ld_gpr1      = uop.ld_gpr1;
      ld_gpr2      = uop.ld_gpr2;
      dcache_write = uop.dcache_write;
    end
  end

  // enables seen by the hazard logic
  always_comb begin
    dep.ld_gpr1      = ld_gpr1 && uop_valid;
    dep.ld_gpr2      = ld_gpr2 && uop_valid;
    dep.dcache_write = dcache_write && uop_valid;
  end

endmodule

//--- verilog/execute.sv
`timescale 1ns/100ps

module execute (
  input  logic               clk,
  input  logic               reset,
  input  logic               stall,
  input  ex_pkg::ex_uop_t    uop,
  input  logic               uop_valid,
  output ex_pkg::wb_bundle_t bundle,
  output ex_pkg::dep_t       dep
);
  import ex_pkg::*;

  word_t b_sel;
  word_t alu_result;
  word_t alu_flags;
  word_t shift_result;
  word_t shift_flags;
  word_t result_a;
  word_t result_b;
  word_t flags;
  logic  ld_gpr1;
  logic  ld_gpr2;
  logic  dcache_write;

  operand_select_ex u_operand_select_ex (
    .clk       (clk),
    .reset     (reset),
    .uop_valid (uop_valid),
    .stall     (stall),
    .uop       (uop),
    .b_sel     (b_sel)
  );

  alu32 u_alu32 (
    .a        (uop.a),
    .b        (b_sel),
    .aluk     (uop.aluk),
    .datasize (uop.datasize),
    .result   (alu_result),
    .flags    (alu_flags)
  );

  shifter32 u_shifter32 (
    .shift_dir (uop.shift_dir),
    .a         (uop.a),
    .b         (b_sel),
    .datasize  (uop.datasize),
    .result    (shift_result),
    .flags     (shift_flags)
  );

  result_select_ex u_result_select_ex (
    .uop          (uop),
    .uop_valid    (uop_valid),
    .alu_result   (alu_result),
    .alu_flags    (alu_flags),
    .shift_result (shift_result),
    .shift_flags  (shift_flags),
    .result_a     (result_a),
    .result_b     (result_b),
    .flags        (flags),
    .ld_gpr1      (ld_gpr1),
    .ld_gpr2      (ld_gpr2),
    .dcache_write (dcache_write),
    .dep          (dep)
  );

  // ex fields pass on to wb
  always_comb begin
    bundle.valid        = uop_valid;
    bundle.neip         = uop.neip;
    bundle.dr1          = uop.dr1;
    bundle.dr2          = uop.dr2;
    bundle.datasize     = uop.datasize;
    bundle.result_a     = result_a;
    bundle.result_b     = result_b;
    bundle.flags        = flags;
    bundle.ld_gpr1      = ld_gpr1;
    bundle.ld_gpr2      = ld_gpr2;
    bundle.dcache_write = dcache_write;
  end

endmodule

//--- verilog/wb_output_latch.sv
`timescale 1ns/100ps

module wb_output_latch (
  input  logic               clk,
  input  logic               reset,
  input  logic               stall,
  input  ex_pkg::wb_bundle_t bundle,
  output ex_pkg::wb_bundle_t wb_out
);
  import ex_pkg::*;

  logic load;

  assign load = !stall;

  // result bundle register
  always_ff @(posedge clk) begin
    if (load) begin
      wb_out <= bundle;
    end
    if (reset) begin
      wb_out.valid <= 1'b0;
    end
  end

endmodule

//--- verilog/ex_stage_top.sv
`timescale 1ns/100ps

module ex_stage_top (
  input  logic               clk,
  input  logic               reset,
  input  logic               ex_v,
  input  ex_pkg::ex_uop_t    ex_in,
  input  logic               wb_stall,
  output ex_pkg::wb_bundle_t wb_out,
  output ex_pkg::dep_t       dep_valid
);
  import ex_pkg::*;

  ex_uop_t    uop;
  logic       uop_valid;
  wb_bundle_t bundle;

  ex_input_latch u_ex_input_latch (
    .clk       (clk),
    .reset     (reset),
    .ex_v      (ex_v),
    .ex_in     (ex_in),
    .stall     (wb_stall),
    .uop       (uop),
    .uop_valid (uop_valid)
  );

  execute u_execute (
    .clk       (clk),
    .reset     (reset),
    .stall     (wb_stall),
    .uop       (uop),
    .uop_valid (uop_valid),
    .bundle    (bundle),
    .dep       (dep_valid)
  );

  wb_output_latch u_wb_output_latch (
    .clk    (clk),
    .reset  (reset),
    .stall  (wb_stall),
    .bundle (bundle),
    .wb_out (wb_out)
  );

endmodule

//--- tb/tb_ex_stage.sv
`include "ex_config.svh"
`timescale 1ns/100ps

module tb_ex_stage;
  import ex_pkg::*;

  localparam int NUM_OPS        = 2000;
  // at most about 7 cycles per micro-op with gaps and stalls
  localparam int TEST_CYCLES    = NUM_OPS * 8 + 100;
  localparam int TIMEOUT_CYCLES = 3 * TEST_CYCLES;

  logic       clk;
  logic       reset;
  logic       ex_v;
  ex_uop_t    ex_in;
  logic       wb_stall;
  wb_bundle_t wb_out;
  dep_t       dep_valid;

  // model state
  wb_bundle_t exp_q[$];
  logic       ex_valid_m;
  dep_t       ex_dep_m;
  word_t      cmps_hold_m;
  logic       last_v;
  logic       last_stall;
  dep_t       last_dep;
  wb_bundle_t prev_wb;
  dep_t       prev_dep;
  int         cycle_count = 0;

  ex_stage_top dut0 (
    .clk       (clk),
    .reset     (reset),
    .ex_v      (ex_v),
    .ex_in     (ex_in),
    .wb_stall  (wb_stall),
    .wb_out    (wb_out),
    .dep_valid (dep_valid)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Test failed");
      $fatal(1, "simulation timed out");
    end
  end

  task automatic check_value(input string name, input logic [159:0] got,
                             input logic [159:0] exp);
    if (got !== exp) begin
      $display("FAILED %s: got %h expected %h", name, got, exp);
      $display("Test failed");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  function automatic word_t pack_flags(input logic cf, input logic zf, input logic sf,
                                       input logic of);
    word_t f;
    f = '0;
    f[`EX_FLAG_CF] = cf;
    f[`EX_FLAG_ZF] = zf;
    f[`EX_FLAG_SF] = sf;
    f[`EX_FLAG_OF] = of;
    return f;
  endfunction

  // reference ALU on signed 64-bit integers
  function automatic word_t model_alu(input ex_uop_t u, input word_t b, output word_t fl);
    longint w, mask, lim, am, bm, sa, sb, s, full;
    logic   cf;
    w    = 8 << u.datasize;
    mask = (longint'(1) << w) - 1;
    lim  = longint'(1) << (w - 1);
    am   = u.a & mask;
    bm   = b & mask;
    sa   = (am >= lim) ? am - 2 * lim : am;
    sb   = (bm >= lim) ? bm - 2 * lim : bm;
    s    = 0;
    cf   = 1'b0;
    case (u.aluk)
      ALU_ADD: begin
        full = am + bm;
        cf   = full > mask;
        s    = sa + sb;
      end
      ALU_SUB: begin
        full = am - bm;
        cf   = am < bm;
        s    = sa - sb;
      end
      ALU_INC: begin
        full = am + 1;
        cf   = full > mask;
        s    = sa + 1;
      end
      ALU_AND:   full = am & bm;
      ALU_OR:    full = am | bm;
      ALU_XOR:   full = am ^ bm;
      ALU_NOT_A: full = ~am;
      default:   full = bm;
    endcase
    full = full & mask;
    fl   = pack_flags(cf, full == 0, full >= lim, (s >= lim) || (s < -lim));
    return word_t'(full);
  endfunction

  function automatic word_t model_shift(input ex_uop_t u, input word_t b, output word_t fl);
    longint w, mask, am, full;
    int     n;
    logic   cf;
    w    = 8 << u.datasize;
    mask = (longint'(1) << w) - 1;
    am   = u.a & mask;
    n    = b[4:0];
    if (!u.shift_dir) begin
      full = (am << n) & mask;
      cf   = (n != 0 && n < w) ? ((am >> (w - n)) & 1) : 1'b0;
    end else begin
      full = am >> n;
      cf   = (n != 0 && n < w) ? ((am >> (n - 1)) & 1) : 1'b0;
    end
    fl = pack_flags(cf, full == 0, (full >> (w - 1)) & 1, 1'b0);
    return word_t'(full);
  endfunction

  function automatic wb_bundle_t expected_bundle(input ex_uop_t u, input word_t hold);
    word_t      bop;
    word_t      alu_res;
    word_t      alu_fl;
    word_t      sh_res;
    word_t      sh_fl;
    wb_bundle_t r;
    bop        = u.is_cmps_second ? hold : u.b;
    alu_res    = model_alu(u, bop, alu_fl);
    sh_res     = model_shift(u, bop, sh_fl);
    r          = '0;
    r.valid    = 1'b1;
    r.neip     = u.neip;
    r.dr1      = u.dr1;
    r.dr2      = u.dr2;
    r.datasize = u.datasize;
    r.flags    = u.use_shifter ? sh_fl : alu_fl;
    r.result_a = u.use_shifter ? sh_res : alu_res;
    r.result_b = u.c;
    r.ld_gpr1      = u.ld_gpr1;
    r.ld_gpr2      = u.ld_gpr2;
    r.dcache_write = u.dcache_write;
    if (u.pass_a) begin
      r.result_a = u.a;
    end else if (u.is_xchg) begin
      r.result_a = u.b;
      r.result_b = u.a;
    end else if (u.is_cmpxchg && r.flags[`EX_FLAG_ZF]) begin
      r.result_a = u.c;
    end else if (u.is_cmpxchg) begin
      r.result_b = u.a;
    end
    // cmpxchg enables follow the compare
    if (u.is_cmpxchg && r.flags[`EX_FLAG_ZF]) begin
      r.ld_gpr2 = 1'b0;
    end else if (u.is_cmpxchg) begin
      r.ld_gpr1      = 1'b0;
      r.ld_gpr2      = 1'b1;
      r.dcache_write = 1'b0;
    end
    return r;
  endfunction

  // kind 0 alu, 1 shift, 2 xchg, 3 pass_a, 4 cmpxchg
  function automatic ex_uop_t random_uop(input int kind);
    ex_uop_t u;
    u              = '0;
    u.neip         = $urandom;
    u.dr1          = reg_idx_t'($urandom_range(7));
    u.dr2          = reg_idx_t'($urandom_range(7));
    u.a            = $urandom;
    u.b            = $urandom;
    u.c            = $urandom;
    u.datasize     = size_t'($urandom_range(2));
    u.aluk         = alu_op_t'($urandom_range(7));
    u.ld_gpr1      = 1'($urandom_range(1));
    u.ld_gpr2      = 1'($urandom_range(1));
    u.dcache_write = 1'($urandom_range(1));
    case (kind)
      1: begin
        u.use_shifter = 1'b1;
        u.shift_dir   = 1'($urandom_range(1));
      end
      2: u.is_xchg = 1'b1;
      3: u.pass_a = 1'b1;
      4: begin
        u.is_cmpxchg = 1'b1;
        u.aluk       = ALU_SUB;
        if ($urandom_range(1) == 1) begin
          u.b = u.a;
        end
      end
      default: ;
    endcase
    return u;
  endfunction

  // junk payload driven while the strobe is low
  function automatic ex_uop_t idle_uop();
    ex_uop_t u;
    u               = random_uop($urandom_range(4));
    u.is_cmps_first = 1'($urandom_range(1));
    return u;
  endfunction

  task automatic check_bundle(input wb_bundle_t e);
    check_value("wb_out.valid", wb_out.valid, e.valid);
    check_value("wb_out.neip", wb_out.neip, e.neip);
    check_value("wb_out.dr1", wb_out.dr1, e.dr1);
    check_value("wb_out.dr2", wb_out.dr2, e.dr2);
    check_value("wb_out.datasize", wb_out.datasize, e.datasize);
    check_value("wb_out.result_a", wb_out.result_a, e.result_a);
    check_value("wb_out.result_b", wb_out.result_b, e.result_b);
    check_value("wb_out.flags", wb_out.flags, e.flags);
    check_value("wb_out.ld_gpr1", wb_out.ld_gpr1, e.ld_gpr1);
    check_value("wb_out.ld_gpr2", wb_out.ld_gpr2, e.ld_gpr2);
    check_value("wb_out.dcache_write", wb_out.dcache_write, e.dcache_write);
  endtask

  // called 1 ns after a rising edge, returns 1 ns after the next one
  task automatic run_cycle(input logic v, input ex_uop_t u, input logic stall);
    wb_bundle_t e;
    logic       wb_new;
    logic       edge_stall;
    dep_t       exp_dep;
    wb_new = 1'b0;
    edge_stall = last_stall;
    if (!last_stall) begin
      wb_new     = ex_valid_m;
      ex_valid_m = last_v;
      ex_dep_m   = last_dep;
    end
    ex_v     = v;
    ex_in    = u;
    wb_stall = stall;
    last_dep = '0;
    if (v) begin
      e = expected_bundle(u, cmps_hold_m);
      exp_q.push_back(e);
      last_dep = {e.ld_gpr1, e.ld_gpr2, e.dcache_write};
      if (u.is_cmps_first) begin
        cmps_hold_m = u.a;
      end
    end
    last_v     = v;
    last_stall = stall;
    @(negedge clk);
    exp_dep = ex_valid_m ? ex_dep_m : dep_t'('0);
    check_value("dep_valid", dep_valid, exp_dep);
    if (edge_stall) begin
      check_value("wb_out (held)", wb_out, prev_wb);
      check_value("dep_valid (held)", dep_valid, prev_dep);
    end else if (wb_new) begin
      e = exp_q.pop_front();
      check_bundle(e);
    end else begin
      check_value("wb_out.valid", wb_out.valid, 1'b0);
    end
    prev_wb  = wb_out;
    prev_dep = dep_valid;
    @(posedge clk);
    #1;
  endtask

  initial begin
    int      issued;
    int      kind;
    ex_uop_t u;
    void'($urandom(32'hfc00));
    reset       = 1'b1;
    ex_v        = 1'b0;
    ex_in       = '0;
    wb_stall    = 1'b0;
    ex_valid_m  = 1'b0;
    ex_dep_m    = '0;
    cmps_hold_m = '0;
    last_v      = 1'b0;
    last_stall  = 1'b0;
    last_dep    = '0;
    repeat (5) @(posedge clk);
    #1;
    reset = 1'b0;

    // cmpxchg with equal and unequal operands at each size
    for (int s = 0; s < 3; s++) begin
      for (int eq = 0; eq < 2; eq++) begin
        u          = random_uop(4);
        u.datasize = size_t'(s);
        u.b        = (eq == 1) ? u.a : (u.a ^ 32'h1);
        run_cycle(1'b1, u, 1'b0);
      end
    end

    issued = 0;
    while (issued < NUM_OPS) begin
      kind = $urandom_range(5);
      if (kind == 5) begin
        // second cmps uop compares its A against the held first A
        u               = random_uop(0);
        u.aluk          = ALU_SUB;
        u.is_cmps_first = 1'b1;
        run_cycle(1'b1, u, 1'b0);
        repeat ($urandom_range(3)) run_cycle(1'b0, idle_uop(), 1'b0);
        u                = random_uop(0);
        u.aluk           = ALU_SUB;
        u.is_cmps_second = 1'b1;
        run_cycle(1'b1, u, 1'b0);
        issued = issued + 2;
      end else begin
        run_cycle(1'b1, random_uop(kind), 1'b0);
        issued = issued + 1;
      end
      if ($urandom_range(3) == 0) begin
        repeat ($urandom_range(2)) run_cycle(1'b0, idle_uop(), 1'b0);
      end
      if ($urandom_range(7) == 0) begin
        repeat ($urandom_range(4, 1)) run_cycle(1'b0, idle_uop(), 1'b1);
      end
    end

    repeat (4) run_cycle(1'b0, idle_uop(), 1'b0);
    check_value("pending bundles", exp_q.size(), 0);
    $display("Test completed successfully");
    $finish;
  end

endmodule

//--- project.f
+incdir+verilog
verilog/ex_pkg.sv
verilog/ex_input_latch.sv
verilog/operand_select_ex.sv
verilog/alu32.sv
verilog/shifter32.sv
verilog/result_select_ex.sv
verilog/execute.sv
verilog/wb_output_latch.sv
verilog/ex_stage_top.sv
tb/tb_ex_stage.sv
